// ==== tb.f ====
hw/bt656_pkg.sv
hw/video_timing_if.sv
hw/bt656_header_decoder.sv
hw/bt656_line_tracker.sv
hw/line_fifo.sv
hw/bt656_rx_top.sv
sim/tb_clock_gen.sv
sim/bt656_rx_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module bt656_rx_tb -f tb.f -o bt656_rx_sim &&
   ./obj_dir/bt656_rx_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" ||
   { echo "simulation run failed"; exit 1; }

// ==== sim/bt656_rx_tb.sv ====
`timescale 1ns/1ns

module bt656_rx_tb;
   import bt656_pkg::*;

   localparam int NUM_ROWS    = 9;
   localparam int BLANK_BYTES = 16;
   localparam int DRAIN_LIMIT = 2000;
   localparam int RESET_LIMIT = 20;

   // one frame of stimulus
   // odd_bytes of 0 means no odd line
   typedef struct
   {
      int lines;
      int bytes;
      int odd_bytes;
      int duty;
      bit enable;
   } row_t;

   logic        clk, rstn;
   logic        rx_enable, err_clr, tready;
   logic [7:0]  data;
   logic        tvalid, tuser, tlast;
   logic [7:0]  tdata;
   logic [11:0] width, height;
   logic        size_err, overflow;
   logic [15:0] frame_cnt;

   row_t        rows [NUM_ROWS];
   // expected beats as {tlast, tuser, tdata}
   logic [9:0]  exp_q [$];
   logic [31:0] rng;
   int          cur_duty;
   bit          lossy;
   bit          frame_seen;
   int          prev_lines;
   logic [15:0] frame_exp;
   logic [11:0] height_exp;

   tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(3)) u_clk_gen
   (
      .clk_o  (clk),
      .rstn_o (rstn)
   );

   bt656_rx_top #(.FIFO_DEPTH(64)) uut
   (
      .clk             (clk),
      .rstn            (rstn),
      .rx_enable_i     (rx_enable),
      .size_err_clr_i  (err_clr),
      .bt656_data_i    (data),
      .m_axis_tvalid_o (tvalid),
      .m_axis_tready_i (tready),
      .m_axis_tdata_o  (tdata),
      .m_axis_tuser_o  (tuser),
      .m_axis_tlast_o  (tlast),
      .width_o         (width),
      .height_o        (height),
      .size_err_o      (size_err),
      .overflow_o      (overflow),
      .frame_cnt_o     (frame_cnt)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic value_error(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic run_error(input string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic send_byte(input logic [7:0] b);
      @(negedge clk);
      data = b;
      rng = xorshift(rng);
      tready = ((rng % 100) < cur_duty);
   endtask

   task automatic send_header(input logic f, input logic v, input logic h);
      logic [7:0] xy;
      xy = 8'h80;
      xy[HDR_BIT_F] = f;
      xy[HDR_BIT_V] = v;
      xy[HDR_BIT_H] = h;
      // protection bits P3..P0
      xy[3:0] = {v ^ h, f ^ h, f ^ v, f ^ v ^ h};
      send_byte(SYNC_PREAMBLE_FF);
      send_byte(SYNC_PREAMBLE_00);
      send_byte(SYNC_PREAMBLE_00);
      send_byte(xy);
   endtask

   task automatic send_blank_line(input logic f);
      send_header(f, 1'b1, 1'b1);
      repeat (BLANK_BYTES) send_byte(8'h10);
      send_header(f, 1'b1, 1'b0);
      repeat (BLANK_BYTES) send_byte(8'h10);
   endtask

   task automatic send_active_line(input int n, input bit first);
      logic [7:0] b;
      send_header(1'b0, 1'b0, 1'b0);
      for (int i = 0; i < n; i++)
      begin
         rng = xorshift(rng);
         b = rng[7:0];
         // 00 and FF would form a false preamble
         while (b == 8'h00 || b == 8'hFF)
         begin
            rng = xorshift(rng);
            b = rng[7:0];
         end
         if (rx_enable)
            exp_q.push_back({(i == n - 1), (first && i == 0), b});
         send_byte(b);
      end
      send_header(1'b0, 1'b0, 1'b1);
      repeat (BLANK_BYTES) send_byte(8'h10);
   endtask

   task automatic drain_stream();
      int cycles;
      cycles = 0;
      cur_duty = 100;
      while (tvalid)
      begin
         send_byte(8'h10);
         cycles++;
         if (cycles > DRAIN_LIMIT)
            run_error("timeout: the stream output did not drain");
      end
   endtask

   task automatic clear_errors();
      @(negedge clk);
      err_clr = 1'b1;
      @(negedge clk);
      err_clr = 1'b0;
      assert (!size_err && !overflow)
      else value_error("error flags still set after the clear pulse");
   endtask

   task automatic check_row_end(input row_t row);
      logic [11:0] width_exp;
      bit          err_exp;
      bit          ovf_exp;
      width_exp = 12'(row.bytes / 2);
      err_exp = (row.odd_bytes != 0);
      ovf_exp = (row.duty == 0);
      assert (width == width_exp)
      else value_error($sformatf("width %0d, expected %0d", width, width_exp));
      assert (size_err == err_exp)
      else value_error($sformatf("size_err %0b, expected %0b", size_err, err_exp));
      assert (overflow == ovf_exp)
      else value_error($sformatf("overflow %0b, expected %0b", overflow, ovf_exp));
      if (err_exp || ovf_exp)
         clear_errors();
   endtask

   task automatic run_row(input row_t row);
      int n;
      if (row.enable && !rx_enable)
      begin
         @(negedge clk);
         rx_enable = 1'b1;
      end
      else if (!row.enable && rx_enable)
      begin
         drain_stream();
         assert (exp_q.size() == 0)
         else run_error($sformatf("%0d expected stream bytes lost before disable",
                                  exp_q.size()));
         @(negedge clk);
         rx_enable = 1'b0;
         lossy = 1'b0;
         frame_seen = 1'b0;
         frame_exp = '0;
         height_exp = '0;
      end
      cur_duty = row.duty;
      if (row.duty == 0)
         lossy = 1'b1;
      send_blank_line(1'b1);
      // F going 1 -> 0 marks the new frame
      send_blank_line(1'b0);
      if (row.enable)
      begin
         frame_exp = frame_exp + 1'b1;
         if (frame_seen)
            height_exp = 12'(prev_lines);
         frame_seen = 1'b1;
         prev_lines = row.lines;
      end
      assert (frame_cnt == frame_exp)
      else value_error($sformatf("frame count %0d, expected %0d", frame_cnt, frame_exp));
      assert (height == height_exp)
      else value_error($sformatf("height %0d, expected %0d", height, height_exp));
      for (int l = 0; l < row.lines; l++)
      begin
         n = (l == 1 && row.odd_bytes != 0) ? row.odd_bytes : row.bytes;
         send_active_line(n, l == 0);
      end
      send_blank_line(1'b0);
      if (row.enable)
         check_row_end(row);
   endtask

   task automatic check_beat();
      logic [9:0] exp;
      // after an overflow only the order of the bytes is known
      if (lossy)
      begin
         while (exp_q.size() > 0 && exp_q[0][7:0] != tdata)
            void'(exp_q.pop_front());
      end
      assert (exp_q.size() > 0)
      else value_error($sformatf("stream byte %02h was not expected", tdata));
      exp = exp_q.pop_front();
      if (!lossy)
      begin
         assert ({tlast, tuser, tdata} == exp)
         else value_error($sformatf("beat last %0b user %0b data %02h, expected %03h",
                                    tlast, tuser, tdata, exp));
      end
   endtask

   always @(posedge clk)
   begin
      if (rstn)
      begin
         if (!rx_enable)
            assert (!tvalid) else value_error("TVALID high while the receiver is disabled");
         if (tvalid && tready)
            check_beat();
      end
   end

   initial
   begin
      int cycles;
      rx_enable = 1'b1;
      err_clr = 1'b0;
      tready = 1'b0;
      data = 8'h10;
      rng = 32'h22e6ff62;
      cur_duty = 100;
      lossy = 1'b0;
      frame_seen = 1'b0;
      prev_lines = 0;
      frame_exp = '0;
      height_exp = '0;

      // lines, bytes per line, odd line bytes, TREADY duty, enable
      rows[0] = '{6, 48, 0, 90, 1'b1};
      rows[1] = '{6, 48, 0, 75, 1'b1};
      rows[2] = '{6, 48, 47, 100, 1'b1};
      rows[3] = '{6, 48, 0, 80, 1'b1};
      rows[4] = '{6, 48, 0, 0, 1'b1};
      rows[5] = '{6, 48, 0, 100, 1'b1};
      rows[6] = '{6, 48, 0, 100, 1'b0};
      rows[7] = '{6, 48, 0, 85, 1'b1};
      rows[8] = '{6, 48, 0, 95, 1'b1};

      cycles = 0;
      while (rstn !== 1'b1)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > RESET_LIMIT)
            run_error("timeout: reset was never released");
      end

      for (int r = 0; r < NUM_ROWS; r++)
         run_row(rows[r]);
      drain_stream();

      if (exp_q.size() == 0)
      begin
         $display("SIMULATION PASSED");
         $finish;
      end
      else
         run_error($sformatf("%0d expected stream bytes never arrived", exp_q.size()));
   end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen
#(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 3
)
(
   output logic clk_o,
   output logic rstn_o
);

   initial
   begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // synchronous reset held low over the first rising edges
   initial
   begin
      rstn_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rstn_o = 1'b1;
   end

endmodule

// ==== hw/bt656_rx_top.sv ====
`timescale 1ns/1ns

module bt656_rx_top
#(
   parameter int FIFO_DEPTH = 64
)
(
   input  logic        clk,
   input  logic        rstn,
   input  logic        rx_enable_i,
   input  logic        size_err_clr_i,
   input  logic [7:0]  bt656_data_i,
   output logic        m_axis_tvalid_o,
   input  logic        m_axis_tready_i,
   output logic [7:0]  m_axis_tdata_o,
   output logic        m_axis_tuser_o,
   output logic        m_axis_tlast_o,
   output logic [11:0] width_o,
   output logic [11:0] height_o,
   output logic        size_err_o,
   output logic        overflow_o,
   output logic [15:0] frame_cnt_o
);
   import bt656_pkg::*;

   logic  wr_en, wr_sof, wr_eol, fifo_full;
   byte_t wr_byte;
   logic  fifo_empty, rd_en, head_sof, head_eol;
   byte_t head_byte;

   video_timing_if timing_bus ();

   bt656_header_decoder u_decoder
   (
      .clk      (clk),
      .rstn     (rstn),
      .enable_i (rx_enable_i),
      .data_i   (bt656_data_i),
      .timing_o (timing_bus.src)
   );

   bt656_line_tracker u_tracker
   (
      .clk         (clk),
      .rstn        (rstn),
      .enable_i    (rx_enable_i),
      .err_clr_i   (size_err_clr_i),
      .timing_i    (timing_bus.dst),
      .fifo_full_i (fifo_full),
      .wr_en_o     (wr_en),
      .wr_byte_o   (wr_byte),
      .wr_sof_o    (wr_sof),
      .wr_eol_o    (wr_eol),
      .width_o     (width_o),
      .height_o    (height_o),
      .size_err_o  (size_err_o),
      .frame_cnt_o (frame_cnt_o),
      .overflow_o  (overflow_o)
   );

   // flushed while the receiver is disabled
   line_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo
   (
      .clk       (clk),
      .rstn      (rstn),
      .flush_i   (!rx_enable_i),
      .wr_en_i   (wr_en),
      .wr_byte_i (wr_byte),
      .wr_sof_i  (wr_sof),
      .wr_eol_i  (wr_eol),
      .full_o    (fifo_full),
      .rd_en_i   (rd_en),
      .empty_o   (fifo_empty),
      .rd_byte_o (head_byte),
      .rd_sof_o  (head_sof),
      .rd_eol_o  (head_eol)
   );

   // stream side, head of the FIFO is the current beat
   assign m_axis_tvalid_o = !fifo_empty && rx_enable_i;
   assign m_axis_tdata_o  = head_byte;
   assign m_axis_tuser_o  = m_axis_tvalid_o && head_sof;
   assign m_axis_tlast_o  = m_axis_tvalid_o && head_eol;
   assign rd_en           = m_axis_tvalid_o && m_axis_tready_i;

endmodule

// ==== hw/line_fifo.sv ====
`timescale 1ns/1ns

module line_fifo
#(
   parameter int FIFO_DEPTH = 64
)
(
   input  logic             clk,
   input  logic             rstn,
   input  logic             flush_i,
   input  logic             wr_en_i,
   input  bt656_pkg::byte_t wr_byte_i,
   input  logic             wr_sof_i,
   input  logic             wr_eol_i,
   output logic             full_o,
   input  logic             rd_en_i,
   output logic             empty_o,
   output bt656_pkg::byte_t rd_byte_o,
   output logic             rd_sof_o,
   output logic             rd_eol_o
);
   import bt656_pkg::*;

   localparam int AW      = $clog2(FIFO_DEPTH);
   localparam int ENTRY_W = $bits(byte_t) + 2;

   // entry is {eol, sof, byte}
   logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
   logic [AW-1:0]      wr_ptr_q, rd_ptr_q;
   logic [AW:0]        count_q;
   logic               wr_ok, rd_ok;

   assign full_o  = (count_q == FIFO_DEPTH[AW:0]);
   assign empty_o = (count_q == '0);
   assign wr_ok   = wr_en_i && !full_o;
   assign rd_ok   = rd_en_i && !empty_o;

   always_ff @(posedge clk)
   begin
      if (wr_ok)
         mem[wr_ptr_q] <= {wr_eol_i, wr_sof_i, wr_byte_i};
   end

   always_ff @(posedge clk)
   begin
      if (!rstn || flush_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (wr_ok)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (rd_ok)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         if (wr_ok && !rd_ok)
            count_q <= count_q + 1'b1;
         else if (rd_ok && !wr_ok)
            count_q <= count_q - 1'b1;
      end
   end

   // show-ahead head of the queue
   assign {rd_eol_o, rd_sof_o, rd_byte_o} = mem[rd_ptr_q];

endmodule

// ==== hw/bt656_line_tracker.sv ====
`timescale 1ns/1ns

module bt656_line_tracker
(
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  enable_i,
   input  logic                  err_clr_i,
   video_timing_if.dst           timing_i,
   input  logic                  fifo_full_i,
   output logic                  wr_en_o,
   output bt656_pkg::byte_t      wr_byte_o,
   output logic                  wr_sof_o,
   output logic                  wr_eol_o,
   output bt656_pkg::dim_t       width_o,
   output bt656_pkg::dim_t       height_o,
   output logic                  size_err_o,
   output bt656_pkg::frame_cnt_t frame_cnt_o,
   output logic                  overflow_o
);
   import bt656_pkg::*;

   // FF 00 00 XY still has to pass the tap after SAV detection
   localparam logic [2:0] HDR_SKIP = 3'd4;
   // one bit more than a pixel count, lines are counted in bytes
   localparam int LEN_W = $bits(dim_t) + 1;

   line_state_e      state_q, state_d;
   logic [2:0]       skip_q;
   logic             field_q;
   logic             sof_pend_q;
   logic             new_frame, sav_active, eav_det, wr_req, line_end;
   logic [LEN_W-1:0] byte_cnt_q, line_len_q, line_bytes;
   logic             width_valid_q, frame_seen_q, height_valid_q;
   dim_t             line_cnt_q, height_q;
   logic             width_err, height_err;

   // F going 1 -> 0 between two headers starts a frame
   assign new_frame  = timing_i.hdr_valid && field_q && !timing_i.field;
   assign sav_active = timing_i.hdr_valid && !timing_i.is_eav && !timing_i.vblank;
   assign eav_det    = timing_i.hdr_valid && timing_i.is_eav;

   assign wr_req   = (state_q == ACTIVE) && (skip_q == '0);
   assign line_end = wr_req && eav_det;

   // tap byte at EAV detection is the last active byte
   assign line_bytes = byte_cnt_q + 1'b1;
   assign width_err  = width_valid_q && (line_bytes != line_len_q);
   assign height_err = height_valid_q && (line_cnt_q != height_q);

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         WAIT_FRAME:
         begin
            if (new_frame)
               state_d = WAIT_SAV;
         end
         WAIT_SAV, BLANK:
         begin
            if (sav_active)
               state_d = ACTIVE;
         end
         ACTIVE:
         begin
            if (line_end)
               state_d = BLANK;
         end
         default:
            state_d = WAIT_FRAME;
      endcase
   end

   assign wr_en_o   = wr_req && !fifo_full_i;
   assign wr_byte_o = timing_i.tap_byte;
   assign wr_sof_o  = sof_pend_q;
   assign wr_eol_o  = eav_det;

   // two bytes per pixel
   assign width_o  = line_len_q[LEN_W-1:1];
   assign height_o = height_q;

   always_ff @(posedge clk)
   begin
      if (!rstn || !enable_i)
      begin
         state_q        <= WAIT_FRAME;
         skip_q         <= '0;
         field_q        <= 1'b0;
         sof_pend_q     <= 1'b0;
         byte_cnt_q     <= '0;
         line_len_q     <= '0;
         width_valid_q  <= 1'b0;
         line_cnt_q     <= '0;
         height_q       <= '0;
         frame_seen_q   <= 1'b0;
         height_valid_q <= 1'b0;
         size_err_o     <= 1'b0;
         overflow_o     <= 1'b0;
         frame_cnt_o    <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (timing_i.hdr_valid)
            field_q <= timing_i.field;

         // header skip on entry to ACTIVE
         if (state_d == ACTIVE && state_q != ACTIVE)
            skip_q <= HDR_SKIP;
         else if (skip_q != '0)
            skip_q <= skip_q - 1'b1;

         if (line_end)
         begin
            byte_cnt_q    <= '0;
            line_len_q    <= line_bytes;
            width_valid_q <= 1'b1;
            line_cnt_q    <= line_cnt_q + 1'b1;
         end
         else if (wr_req)
            byte_cnt_q <= byte_cnt_q + 1'b1;

         if (wr_en_o)
            sof_pend_q <= 1'b0;

         if (new_frame)
         begin
            sof_pend_q   <= 1'b1;
            frame_cnt_o  <= frame_cnt_o + 1'b1;
            frame_seen_q <= 1'b1;
            line_cnt_q   <= '0;
            // nothing counted before the first frame start
            if (frame_seen_q)
            begin
               height_q       <= line_cnt_q;
               height_valid_q <= 1'b1;
            end
         end

         if (err_clr_i)
         begin
            size_err_o <= 1'b0;
            overflow_o <= 1'b0;
         end
         if ((line_end && width_err) || (new_frame && height_err))
            size_err_o <= 1'b1;
         if (wr_req && fifo_full_i)
            overflow_o <= 1'b1;
      end
   end

endmodule

// ==== hw/bt656_header_decoder.sv ====
`timescale 1ns/1ns

module bt656_header_decoder
(
   input  logic              clk,
   input  logic              rstn,
   input  logic              enable_i,
   input  bt656_pkg::byte_t  data_i,
   video_timing_if.src       timing_o
);
   import bt656_pkg::*;

   localparam int DLY_LEN = 5;

   // dly_q[0] is the newest byte, dly_q[DLY_LEN-1] is the tap
   byte_t dly_q [DLY_LEN];
   byte_t xy_byte;
   logic  preamble_hit;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         for (int i = 0; i < DLY_LEN; i++)
         begin
            dly_q[i] <= SYNC_PREAMBLE_00;
         end
      end
      else
      begin
         dly_q[0] <= data_i;
         for (int i = 1; i < DLY_LEN; i++)
         begin
            dly_q[i] <= dly_q[i-1];
         end
      end
   end

   // FF 00 00 in the three stages behind the XY byte
   assign preamble_hit = (dly_q[3] == SYNC_PREAMBLE_FF) &&
                         (dly_q[2] == SYNC_PREAMBLE_00) &&
                         (dly_q[1] == SYNC_PREAMBLE_00);

   assign xy_byte = dly_q[0];

   assign timing_o.hdr_valid = enable_i && preamble_hit;

   // H set means EAV, clear means SAV
   assign timing_o.is_eav = xy_byte[HDR_BIT_H];
   assign timing_o.vblank = xy_byte[HDR_BIT_V];
   assign timing_o.field  = xy_byte[HDR_BIT_F];

   // byte just before the FF when a header is seen
   assign timing_o.tap_byte = dly_q[DLY_LEN-1];

endmodule

// ==== hw/video_timing_if.sv ====
`timescale 1ns/1ns

interface video_timing_if;
   import bt656_pkg::*;

   // decoded timing reference, one-cycle pulse
   logic  hdr_valid;
   logic  is_eav;
   logic  vblank;
   logic  field;
   // byte leaving the decoder delay line
   byte_t tap_byte;

   modport src
   (
      output hdr_valid, is_eav, vblank, field, tap_byte
   );

   modport dst
   (
      input hdr_valid, is_eav, vblank, field, tap_byte
   );

endinterface

// ==== hw/bt656_pkg.sv ====
package bt656_pkg;

   // one video sample on the BT.656 bus
   typedef logic [7:0] byte_t;

   // width in pixels or height in lines
   typedef logic [11:0] dim_t;

   // frames received since enable
   typedef logic [15:0] frame_cnt_t;

   // F, V and H bits inside the XY byte
   localparam int HDR_BIT_F = 6;
   localparam int HDR_BIT_V = 5;
   localparam int HDR_BIT_H = 4;

   // timing reference preamble FF 00 00
   localparam byte_t SYNC_PREAMBLE_FF = 8'hFF;
   localparam byte_t SYNC_PREAMBLE_00 = 8'h00;

   // line tracker states
   typedef enum logic [1:0]
   {
      WAIT_FRAME = 2'b00,
      WAIT_SAV   = 2'b01,
      ACTIVE     = 2'b10,
      BLANK      = 2'b11
   } line_state_e;

endpackage
